//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/decode_config.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/control.sv
`timescale 1ns/1ps

module control (
    input  decode_pkg::instruction_type instruction,
    output decode_pkg::control_type     control
);

    always_comb begin
        control = '0;               // unlisted opcodes stay all zero

        case (instruction.opcode)
            // R type, add sub sll slt sltu xor srl sra or and
            7'b0110011: begin
                control.encoding  = decode_pkg::R_TYPE;
                control.reg_write = 1'b1;

                unique casez ({instruction.funct7[5], instruction.funct3})
                    4'b0_000: control.alu_op = decode_pkg::ALU_ADD;
                    4'b1_000: control.alu_op = decode_pkg::ALU_SUB;
                    4'b?_001: control.alu_op = decode_pkg::ALU_SLL;
                    4'b?_010: control.alu_op = decode_pkg::ALU_SLT;
                    4'b?_011: control.alu_op = decode_pkg::ALU_SLTU;
                    4'b?_100: control.alu_op = decode_pkg::ALU_XOR;
                    4'b0_101: control.alu_op = decode_pkg::ALU_SRL;
                    4'b1_101: control.alu_op = decode_pkg::ALU_SRA;
                    4'b?_110: control.alu_op = decode_pkg::ALU_OR;
                    4'b?_111: control.alu_op = decode_pkg::ALU_AND;
                endcase
            end

            // I type alu ops with immediate
            7'b0010011: begin
                control.encoding  = decode_pkg::I_TYPE;
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;

                unique casez ({instruction.funct7[5], instruction.funct3})
                    4'b?_000: control.alu_op = decode_pkg::ALU_ADD;   // addi, no subi
                    4'b?_001: control.alu_op = decode_pkg::ALU_SLL;
                    4'b?_010: control.alu_op = decode_pkg::ALU_SLT;
                    4'b?_011: control.alu_op = decode_pkg::ALU_SLTU;
                    4'b?_100: control.alu_op = decode_pkg::ALU_XOR;
                    4'b0_101: control.alu_op = decode_pkg::ALU_SRL;   // srli
                    4'b1_101: control.alu_op = decode_pkg::ALU_SRA;   // srai
                    4'b?_110: control.alu_op = decode_pkg::ALU_OR;
                    4'b?_111: control.alu_op = decode_pkg::ALU_AND;
                endcase
            end

            // loads, address is rs1 + imm for every width
            7'b0000011: begin
                control.encoding   = decode_pkg::I_TYPE;
                control.reg_write  = 1'b1;
                control.alu_src    = 1'b1;
                control.mem_read   = 1'b1;
                control.mem_to_reg = 1'b1;
                control.alu_op     = decode_pkg::ALU_ADD;
            end

            // jalr
            7'b1100111: begin
                control.encoding = decode_pkg::I_TYPE;
            end

            // jal
            7'b1101111: begin
                control.encoding = decode_pkg::J_TYPE;
            end

            // stores sb sh sw
            7'b0100011: begin
                control.encoding  = decode_pkg::S_TYPE;
                control.alu_src   = 1'b1;
                control.mem_write = 1'b1;
                control.alu_op    = decode_pkg::ALU_ADD;
            end

            // branches
            7'b1100011: begin
                control.encoding  = decode_pkg::B_TYPE;
                control.is_branch = 1'b1;

                unique case (instruction.funct3)
                    3'b000:  control.alu_op = decode_pkg::ALU_SUB;    // beq
                    3'b001:  control.alu_op = decode_pkg::B_BNE;
                    3'b100:  control.alu_op = decode_pkg::B_BLT;
                    3'b101:  control.alu_op = decode_pkg::B_BGE;
                    3'b110:  control.alu_op = decode_pkg::B_LTU;
                    3'b111:  control.alu_op = decode_pkg::B_GEU;
                    default: control.alu_op = decode_pkg::ALU_NONE;   // 010, 011 undefined
                endcase
            end

            // lui
            7'b0110111: begin
                control.encoding  = decode_pkg::U_TYPE;
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
                control.alu_op    = decode_pkg::ALU_LUI;
            end

            // auipc, pc + imm
            7'b0010111: begin
                control.encoding  = decode_pkg::U_TYPE;
                control.reg_write = 1'b1;
                control.alu_op    = decode_pkg::ALU_ADD;
            end

            default: begin
                control = '0;
            end
        endcase
    end

endmodule

//--- rtl/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// fetch buffer entries, keep a power of two
`define FETCH_DEPTH 4

// pc of the first word after reset
`define RESET_PC 32'h0000_0000

`endif

//--- rtl/decode_pkg.sv
package decode_pkg;

    // raw rv32i word, base field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instruction_type;

    typedef enum logic [2:0] {
        NONE   = 3'd0,
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } encoding_type;

    // branch compares share the alu op space
    typedef enum logic [4:0] {
        ALU_NONE = 5'd0,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        B_BNE,
        B_BLT,
        B_BGE,
        B_LTU,
        B_GEU
    } alu_op_type;

    typedef struct packed {
        encoding_type encoding;
        alu_op_type   alu_op;
        logic         alu_src;     // second operand from imm
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        logic         mem_to_reg;
        logic         is_branch;
    } control_type;

    // fifo payload
    typedef struct packed {
        logic [31:0]     pc;
        instruction_type instruction;
    } fetch_entry_type;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;
        control_type control;
    } decoded_type;

endpackage

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        empty,
    input  decode_pkg::fetch_entry_type pop_data,
    input  logic                        stall,
    output logic                        pop,
    output logic                        dec_valid,
    output decode_pkg::decoded_type     dec
);

    decode_pkg::control_type ctrl;
    decode_pkg::decoded_type dec_next;
    logic [31:0]             imm;

    control i_control (
        .instruction (pop_data.instruction),
        .control     (ctrl)
    );

    imm_gen i_imm_gen (
        .instruction (pop_data.instruction),
        .encoding    (ctrl.encoding),
        .imm         (imm)
    );

    // head entry is consumed the same edge it gets registered
    assign pop = !empty && !stall;

    always_comb begin
        dec_next.pc      = pop_data.pc;
        dec_next.rd      = pop_data.instruction.rd;
        dec_next.rs1     = pop_data.instruction.rs1;
        dec_next.rs2     = pop_data.instruction.rs2;
        dec_next.funct3  = pop_data.instruction.funct3;
        dec_next.imm     = imm;
        dec_next.control = ctrl;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= pop;       // one pulse per popped entry
        end
    end

    // record holds its last value between pops
    always_ff @(posedge clk) begin
        if (pop) begin
            dec <= dec_next;
        end
    end

endmodule

//--- rtl/decode_top.sv
`timescale 1ns/1ps

`include "decode_config.svh"

module decode_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_valid,
    input  decode_pkg::instruction_type instr,
    input  logic                        stall,
    output logic                        fetch_full,
    output logic                        dec_valid,
    output decode_pkg::decoded_type     dec
);

    logic                        push;
    logic                        pop;
    logic                        empty;
    decode_pkg::fetch_entry_type push_data;
    decode_pkg::fetch_entry_type pop_data;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .push        (push),
        .push_data   (push_data)
    );

    // almost full leaves one slot for the word still in the fetch register
    fetch_fifo #(
        .payload_t (decode_pkg::fetch_entry_type),
        .DEPTH     (`FETCH_DEPTH)
    ) i_fetch_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty),
        .almost_full (fetch_full)
    );

    decode_stage i_decode_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (empty),
        .pop_data  (pop_data),
        .stall     (stall),
        .pop       (pop),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

endmodule

//--- rtl/fetch_fifo.sv
`timescale 1ns/1ps

module fetch_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [CNT_W-1:0] FULL_LEVEL   = CNT_W'(DEPTH);
    localparam logic [CNT_W-1:0] ALMOST_LEVEL = CNT_W'(DEPTH - 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty       = (count == '0);
    assign almost_full = (count >= ALMOST_LEVEL);

    // drop writes into a full buffer, ignore pops from an empty one
    assign do_push = push && (count != FULL_LEVEL);
    assign do_pop  = pop && !empty;

    // show-ahead head entry
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle or simultaneous
            endcase
        end
    end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

`include "decode_config.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_valid,
    input  decode_pkg::instruction_type instr,
    output logic                        push,
    output decode_pkg::fetch_entry_type push_data
);

    logic [31:0] pc;

    // running pc, one word per strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc   <= `RESET_PC;
            push <= 1'b0;
        end else begin
            push <= instr_valid;             // one cycle after the strobe
            if (instr_valid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // entry register, payload only
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            push_data.pc          <= pc;
            push_data.instruction <= instr;
        end
    end

endmodule

//--- rtl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::instruction_type instruction,
    input  decode_pkg::encoding_type    encoding,
    output logic [31:0]                 imm
);

    logic [31:0] word;

    assign word = instruction;      // flat view for the bit slicing

    always_comb begin
        case (encoding)
            decode_pkg::I_TYPE: begin
                imm = {{20{word[31]}}, word[31:20]};
            end

            decode_pkg::S_TYPE: begin
                imm = {{20{word[31]}}, word[31:25], word[11:7]};
            end

            // branch offset, bit 0 always zero
            decode_pkg::B_TYPE: begin
                imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            end

            decode_pkg::U_TYPE: begin
                imm = {word[31:12], 12'h000};
            end

            decode_pkg::J_TYPE: begin
                imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            end

            default: begin
                imm = 32'h0000_0000;        // R type and none
            end
        endcase
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/fetch_unit.sv
rtl/fetch_fifo.sv
rtl/control.sv
rtl/imm_gen.sv
rtl/decode_stage.sv
rtl/decode_top.sv
tb/tb_decode_top.sv

//--- tb/tb_decode_top.sv
`timescale 1ns/1ps

`include "decode_config.svh"

module tb_decode_top;

    localparam int LIMIT = 300;     // cycles allowed per wait

    logic                        clk = 1'b0;
    logic                        arst_n;
    logic                        instr_valid;
    decode_pkg::instruction_type instr;
    logic                        stall;
    logic                        fetch_full;
    logic                        dec_valid;
    decode_pkg::decoded_type     dec;

    decode_pkg::decoded_type exp_q[$];
    decode_pkg::decoded_type exp_rec;
    integer      seed = 32'h16f7;
    logic [31:0] rnd;
    logic [31:0] pc_model;
    logic        rand_stall_en = 1'b0;
    logic        prev_stall = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;

    decode_top i_decode_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .fetch_full  (fetch_full),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    always #4 clk = ~clk;

    function automatic decode_pkg::alu_op_type alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    alu_sel = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'd1:    alu_sel = decode_pkg::ALU_SLL;
            3'd2:    alu_sel = decode_pkg::ALU_SLT;
            3'd3:    alu_sel = decode_pkg::ALU_SLTU;
            3'd4:    alu_sel = decode_pkg::ALU_XOR;
            3'd5:    alu_sel = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'd6:    alu_sel = decode_pkg::ALU_OR;
            default: alu_sel = decode_pkg::ALU_AND;
        endcase
    endfunction

    // expected record from the opcode table and the rv32i immediate forms
    function automatic decode_pkg::decoded_type ref_decode(input logic [31:0] pc,
                                                           input logic [31:0] w);
        decode_pkg::decoded_type d;
        d = '0;
        d.pc     = pc;
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = w[14:12];
        case (w[6:0])
            7'b0110011: begin
                d.control.encoding  = decode_pkg::R_TYPE;
                d.control.reg_write = 1'b1;
                d.control.alu_op    = alu_sel(w[14:12], w[30]);
            end
            7'b0010011: begin
                d.control.encoding  = decode_pkg::I_TYPE;
                d.control.reg_write = 1'b1;
                d.control.alu_src   = 1'b1;
                d.control.alu_op    = alu_sel(w[14:12], w[30] && (w[14:12] == 3'd5));
            end
            7'b0000011: begin
                d.control.encoding   = decode_pkg::I_TYPE;
                d.control.reg_write  = 1'b1;
                d.control.alu_src    = 1'b1;
                d.control.mem_read   = 1'b1;
                d.control.mem_to_reg = 1'b1;
                d.control.alu_op     = decode_pkg::ALU_ADD;
            end
            7'b0100011: begin
                d.control.encoding  = decode_pkg::S_TYPE;
                d.control.alu_src   = 1'b1;
                d.control.mem_write = 1'b1;
                d.control.alu_op    = decode_pkg::ALU_ADD;
            end
            7'b1100011: begin
                d.control.encoding  = decode_pkg::B_TYPE;
                d.control.is_branch = 1'b1;
                case (w[14:12])
                    3'd0:    d.control.alu_op = decode_pkg::ALU_SUB;
                    3'd1:    d.control.alu_op = decode_pkg::B_BNE;
                    3'd4:    d.control.alu_op = decode_pkg::B_BLT;
                    3'd5:    d.control.alu_op = decode_pkg::B_BGE;
                    3'd6:    d.control.alu_op = decode_pkg::B_LTU;
                    3'd7:    d.control.alu_op = decode_pkg::B_GEU;
                    default: d.control.alu_op = decode_pkg::ALU_NONE;
                endcase
            end
            7'b0110111: begin
                d.control.encoding  = decode_pkg::U_TYPE;
                d.control.reg_write = 1'b1;
                d.control.alu_src   = 1'b1;
                d.control.alu_op    = decode_pkg::ALU_LUI;
            end
            7'b0010111: begin
                d.control.encoding  = decode_pkg::U_TYPE;
                d.control.reg_write = 1'b1;
                d.control.alu_op    = decode_pkg::ALU_ADD;
            end
            7'b1100111: d.control.encoding = decode_pkg::I_TYPE;
            7'b1101111: d.control.encoding = decode_pkg::J_TYPE;
            default:    d.control = '0;
        endcase
        case (d.control.encoding)
            decode_pkg::I_TYPE: d.imm = {{20{w[31]}}, w[31:20]};
            decode_pkg::S_TYPE: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            decode_pkg::B_TYPE: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            decode_pkg::U_TYPE: d.imm = {w[31:12], 12'h000};
            decode_pkg::J_TYPE: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:            d.imm = 32'h0;
        endcase
        return d;
    endfunction

    // scoreboard, values read at the edge are the settled ones of the past cycle
    always @(posedge clk) begin
        if (arst_n && dec_valid) begin
            checks++;
            assert (!prev_stall) else begin
                $display("CHECK FAILED at %0t: dec_valid after a stalled cycle", $time);
                errors++;
            end
            assert (exp_q.size() != 0) else begin
                $display("error at %0t: dec_valid with no instruction outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                assert (dec === exp_rec) else begin
                    $display("CHECK FAILED at %0t: pc %h/%h rd %h/%h rs1 %h/%h rs2 %h/%h%s",
                             $time, dec.pc, exp_rec.pc, dec.rd, exp_rec.rd,
                             dec.rs1, exp_rec.rs1, dec.rs2, exp_rec.rs2,
                             $sformatf(" f3 %h/%h imm %h/%h ctrl %h/%h (got/exp)",
                                       dec.funct3, exp_rec.funct3, dec.imm, exp_rec.imm,
                                       dec.control, exp_rec.control));
                    errors++;
                end
            end
        end
        prev_stall = stall;
    end

    always @(posedge clk) begin
        if (rand_stall_en) begin
            rnd = $random(seed);
            stall <= rnd[0];
        end
    end

    function automatic logic [31:0] mk_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [6:0] op);
        return {f7, 5'd3, 5'd17, f3, 5'd9, op};
    endfunction

    // one strobe, only while fetch_full is low
    task automatic send_word(input logic [31:0] w);
        int t;
        t = 0;
        @(posedge clk);
        while (fetch_full) begin
            t++;
            if (t > LIMIT) begin
                $display("timeout waiting for fetch_full to drop");
                $display("Test FAILED");
                $finish;
            end
            @(posedge clk);
        end
        instr       <= w;
        instr_valid <= 1'b1;
        exp_q.push_back(ref_decode(pc_model, w));
        pc_model = pc_model + 32'd4;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            t++;
            if (t > LIMIT) begin
                $display("timeout waiting for dec_valid");
                $display("Test FAILED");
                $finish;
            end
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        int          e0;
        int          lat;
        logic [6:0]  ops[8];
        logic [31:0] words[40];
        logic [31:0] w;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        pc_model    = `RESET_PC;
        ops = '{7'h13, 7'h03, 7'h67, 7'h23, 7'h63, 7'h37, 7'h17, 7'h6f};
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        e0 = errors;
        assert (!dec_valid && !fetch_full) else begin
            $display("CHECK FAILED at %0t: dec_valid or fetch_full high after reset", $time);
            errors++;
        end
        end_test("reset state", e0);

        // single strobe latency, counted from the sampling edge
        e0 = errors;
        @(posedge clk);
        instr       <= mk_word(7'h00, 3'd0, 7'h33);
        instr_valid <= 1'b1;
        exp_q.push_back(ref_decode(pc_model, mk_word(7'h00, 3'd0, 7'h33)));
        pc_model = pc_model + 32'd4;
        @(posedge clk);
        instr_valid <= 1'b0;
        lat = 0;
        while (!dec_valid) begin
            @(posedge clk);
            lat++;
            if (lat > LIMIT) begin
                $display("timeout waiting for dec_valid");
                $display("Test FAILED");
                $finish;
            end
        end
        assert (lat == 3) else begin
            $display("CHECK FAILED at %0t: latency %0d cycles, expected 3", $time, lat);
            errors++;
        end
        drain();
        // back to back strobes
        for (int i = 0; i < 4; i++) begin
            w = mk_word(7'h00, 3'(i), 7'h33);
            @(posedge clk);
            instr       <= w;
            instr_valid <= 1'b1;
            exp_q.push_back(ref_decode(pc_model, w));
            pc_model = pc_model + 32'd4;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        lat = 0;
        while (!dec_valid) begin
            @(posedge clk);
            lat++;
            if (lat > LIMIT) begin
                $display("timeout waiting for dec_valid");
                $display("Test FAILED");
                $finish;
            end
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            assert (dec_valid) else begin
                $display("CHECK FAILED at %0t: gap in back to back dec_valid", $time);
                errors++;
            end
        end
        drain();
        end_test("latency and back to back", e0);

        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            send_word(mk_word(i[3] ? 7'h20 : 7'h00, 3'(i), 7'h33));
            send_word(mk_word(i[3] ? 7'h20 : 7'h00, 3'(i), 7'h13));
        end
        for (int i = 0; i < 8; i++) begin
            if (i != 2 && i != 3) begin
                send_word(mk_word(7'h00, 3'(i), 7'h63));
            end
        end
        send_word(mk_word(7'h00, 3'd2, 7'h03));
        send_word(mk_word(7'h00, 3'd2, 7'h23));
        send_word(mk_word(7'h12, 3'd0, 7'h37));
        send_word(mk_word(7'h12, 3'd0, 7'h17));
        send_word(mk_word(7'h00, 3'd0, 7'h67));
        send_word(mk_word(7'h40, 3'd0, 7'h6f));
        drain();
        end_test("control table", e0);

        e0 = errors;
        for (int c = 0; c < 8; c++) begin
            for (int k = 0; k < 8; k++) begin
                rnd = $random(seed);
                w = {k[0], rnd[30:7], ops[c]};   // both sign cases
                send_word(w);
            end
        end
        drain();
        end_test("immediates", e0);

        e0 = errors;
        send_word(mk_word(7'h00, 3'd2, 7'h63));
        send_word(mk_word(7'h20, 3'd3, 7'h63));
        send_word(mk_word(7'h7f, 3'd5, 7'h7f));
        send_word(mk_word(7'h00, 3'd0, 7'h00));
        send_word(mk_word(7'h11, 3'd1, 7'h0b));
        drain();
        end_test("unknown opcodes", e0);

        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            words[i] = $random(seed);
        end
        rand_stall_en <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_word(words[i]);
        end
        rand_stall_en <= 1'b0;
        @(posedge clk);
        stall <= 1'b0;
        drain();
        end_test("random stall", e0);

        e0 = errors;
        @(posedge clk);
        stall <= 1'b1;
        for (int i = 0; i < `FETCH_DEPTH - 2; i++) begin
            send_word(mk_word(7'h00, 3'(i), 7'h13));
        end
        repeat (3) @(posedge clk);
        assert (!fetch_full) else begin
            $display("CHECK FAILED at %0t: fetch_full high too early", $time);
            errors++;
        end
        send_word(mk_word(7'h00, 3'd7, 7'h13));
        lat = 0;
        while (!fetch_full) begin
            @(posedge clk);
            lat++;
            if (lat > 10) begin
                $display("timeout waiting for fetch_full");
                $display("Test FAILED");
                $finish;
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        drain();
        assert (!fetch_full) else begin
            $display("CHECK FAILED at %0t: fetch_full still high after drain", $time);
            errors++;
        end
        end_test("fill and drain", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
